// ==== verilog/rp_dsp_pkg.sv ====
// sample path types
// signed samples, raw adc words and gain/offset calibration

package rp_dsp_pkg;

  // signed sample shared by adc and dac streams
  typedef logic signed [14-1:0] sample_t;

  // adc pin word, lowest 2 bits of the 16-bit bus are reserved
  typedef logic [16-1:2] adc_raw_t;

  // gain, 16384 stands for one
  typedef logic signed [16-1:0] gain_t;
  // offset added after scaling
  typedef logic signed [14-1:0] offset_t;

  // full product of sample and gain
  typedef logic signed [$bits(sample_t)+$bits(gain_t)-1:0] prod_t;

  // per channel calibration
  typedef struct packed {
    gain_t   gain;
    offset_t offset;
  } cal_t;

  // scaling constants
  parameter int unsigned GAIN_SHIFT = 14;
  parameter gain_t       GAIN_ONE   = 16'sd16384;

  // saturation limits of sample_t
  parameter sample_t SMP_MAX = 14'sd8191;
  parameter sample_t SMP_MIN = -14'sd8192;

endpackage : rp_dsp_pkg

// ==== verilog/rp_bus_pkg.sv ====
// register bus definitions
// request/response structs, register map and register word layout

package rp_bus_pkg;

  import rp_dsp_pkg::*;

  // address and data
  typedef logic [3-1:0]  addr_t;
  typedef logic [32-1:0] data_t;

  // register map
  parameter addr_t ADDR_CTL     = 3'd0;
  // first of the adc calibration words, one per channel
  parameter addr_t ADDR_ADC_CAL = 3'd1;
  // first of the dac calibration words
  parameter addr_t ADDR_DAC_CAL = 3'd3;

  // loop field width in the control word
  parameter int unsigned LOOP_W = 2;

  // master side, four-phase req/ack
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // slave side
  typedef struct packed {
    logic  ack;
    data_t rdata;
  } bus_rsp_t;

  // one data word, two views selected by address
  typedef union packed {
    struct packed {
      logic [2-1:0] pad;
      cal_t         cal;
    } cal;
    struct packed {
      logic [32-LOOP_W-1:0] pad;
      logic [LOOP_W-1:0]    loop;
    } ctl;
  } reg_word_u;

  // calibration after reset, unity gain and no offset
  parameter cal_t CAL_RESET = '{gain: GAIN_ONE, offset: 14'sd0};

endpackage : rp_bus_pkg

// ==== verilog/rp_regs.sv ====
// register bank
// four-phase req/ack access to loopback and calibration settings

module rp_regs import rp_dsp_pkg::*, rp_bus_pkg::*; #(
  parameter int unsigned CHN = 2
) (
  input  logic               adc_clk,
  input  logic               top_rst,
  // register bus
  input  bus_req_t           bus_req_i,
  output bus_rsp_t           bus_rsp_o,
  // settings
  output logic [CHN-1:0]     loop_o,
  output cal_t [CHN-1:0]     adc_cal_o,
  output cal_t [CHN-1:0]     dac_cal_o
);

  //////////////////////////////
  // local signals
  //////////////////////////////

  logic             ack_q;
  logic             access;
  data_t            rdata_q;
  reg_word_u        wr_word;
  reg_word_u        rd_word;
  logic [CHN-1:0]   loop_q;
  cal_t [CHN-1:0]   adc_cal_q;
  cal_t [CHN-1:0]   dac_cal_q;

  // access happens once, on the first cycle req is seen
  assign access  = bus_req_i.req & ~ack_q;
  assign wr_word = bus_req_i.wdata;

  //////////////////////////////
  // read decode
  //////////////////////////////

  always_comb begin
    // unmapped addresses and pad bits read zero
    rd_word = '0;
    if (bus_req_i.addr == ADDR_CTL) begin
      rd_word.ctl.loop[CHN-1:0] = loop_q;
    end
    for (int i = 0; i < CHN; i++) begin
      if (bus_req_i.addr == addr_t'(ADDR_ADC_CAL + i)) begin
        rd_word.cal.cal = adc_cal_q[i];
      end
      if (bus_req_i.addr == addr_t'(ADDR_DAC_CAL + i)) begin
        rd_word.cal.cal = dac_cal_q[i];
      end
    end
  end

  //////////////////////////////
  // settings and handshake
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      ack_q     <= 1'b0;
      loop_q    <= '0;
      adc_cal_q <= {CHN{CAL_RESET}};
      dac_cal_q <= {CHN{CAL_RESET}};
    end else begin
      // ack follows req by one cycle, both edges
      ack_q <= bus_req_i.req;
      if (access && bus_req_i.we) begin
        if (bus_req_i.addr == ADDR_CTL) begin
          loop_q <= wr_word.ctl.loop[CHN-1:0];
        end
        for (int i = 0; i < CHN; i++) begin
          if (bus_req_i.addr == addr_t'(ADDR_ADC_CAL + i)) begin
            adc_cal_q[i] <= wr_word.cal.cal;
          end
          if (bus_req_i.addr == addr_t'(ADDR_DAC_CAL + i)) begin
            dac_cal_q[i] <= wr_word.cal.cal;
          end
        end
      end
    end
  end

  // read data captured with the access
  always_ff @(posedge adc_clk) begin
    if (access) begin
      rdata_q <= rd_word;
    end
  end

  assign bus_rsp_o = '{ack: ack_q, rdata: rdata_q};
  assign loop_o    = loop_q;
  assign adc_cal_o = adc_cal_q;
  assign dac_cal_o = dac_cal_q;

  // ack only rises while req is still held
  a_ack_rise : assert property (@(posedge adc_clk) disable iff (top_rst)
    $rose(bus_rsp_o.ack) |-> bus_req_i.req)
    else $error("ERR ack rose without req");

  // master holds the access stable until it is acknowledged
  a_req_stable : assert property (@(posedge adc_clk) disable iff (top_rst)
    bus_req_i.req && !bus_rsp_o.ack |=>
      bus_req_i.req && $stable({bus_req_i.we, bus_req_i.addr, bus_req_i.wdata}))
    else $error("ERR request changed before ack");

endmodule : rp_regs

// ==== verilog/rp_adc_front.sv ====
// adc front end
// captures raw adc words, converts offset binary to signed, loopback select

module rp_adc_front import rp_dsp_pkg::*; #(
  parameter int unsigned CHN = 2
) (
  input  logic                adc_clk,
  input  logic                top_rst,
  // adc pins
  input  adc_raw_t [CHN-1:0]  adc_dat_i,
  // loopback control and source
  input  logic [CHN-1:0]      loop_i,
  input  sample_t [CHN-1:0]   dac_smp_i,
  // toward adc calibration
  output sample_t [CHN-1:0]   adc_smp_o
);

  //////////////////////////////
  // capture
  //////////////////////////////

  sample_t [CHN-1:0] adc_q;

  // one register stage at the pins
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_q <= '0;
    end else begin
      for (int i = 0; i < CHN; i++) begin
        // msb kept, rest inverted
        // offset binary with negative slope becomes signed
        adc_q[i] <= {adc_dat_i[i][16-1], ~adc_dat_i[i][16-2:2]};
      end
    end
  end

  //////////////////////////////
  // loopback mux
  //////////////////////////////

  // combinational, looped sample skips the capture stage
  always_comb begin
    for (int i = 0; i < CHN; i++) begin
      adc_smp_o[i] = loop_i[i] ? dac_smp_i[i] : adc_q[i];
    end
  end

endmodule : rp_adc_front

// ==== verilog/rp_linear.sv ====
// linear calibration
// two-stage gain, offset and saturation for CHN sample streams

module rp_linear import rp_dsp_pkg::*; #(
  parameter int unsigned CHN = 2
) (
  input  logic               adc_clk,
  input  logic               top_rst,
  // sample stream in
  input  sample_t [CHN-1:0]  smp_i,
  // per channel gain and offset
  input  cal_t [CHN-1:0]     cal_i,
  // calibrated stream out
  output sample_t [CHN-1:0]  smp_o
);

  //////////////////////////////
  // stage 1, multiply
  //////////////////////////////

  prod_t [CHN-1:0]   prod_q;
  offset_t [CHN-1:0] off_q;
  sample_t [CHN-1:0] sat;

  // offset travels with its product
  // so one sample sees one calibration setting
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
      off_q  <= '0;
    end else begin
      for (int i = 0; i < CHN; i++) begin
        prod_q[i] <= smp_i[i] * cal_i[i].gain;
        off_q[i]  <= cal_i[i].offset;
      end
    end
  end

  //////////////////////////////
  // stage 2, scale and clip
  //////////////////////////////

  always_comb begin
    // one spare bit above the product holds the offset carry
    logic signed [$bits(prod_t):0] sum;
    for (int i = 0; i < CHN; i++) begin
      sum = (prod_q[i] >>> GAIN_SHIFT) + off_q[i];
      // clip to sample range
      if (sum > SMP_MAX) begin
        sat[i] = SMP_MAX;
      end else if (sum < SMP_MIN) begin
        sat[i] = SMP_MIN;
      end else begin
        sat[i] = sample_t'(sum);
      end
    end
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else begin
      smp_o <= sat;
    end
  end

  // X on a stage input shows up here two cycles later
  a_no_x : assert property (@(posedge adc_clk) disable iff (top_rst) !$isunknown(smp_o))
    else $error("ERR calibrated sample unknown");

endmodule : rp_linear

// ==== verilog/rp_dac_out.sv ====
// dac output formatter
// signed samples to offset binary with inverted slope, registered

module rp_dac_out import rp_dsp_pkg::*; #(
  parameter int unsigned CHN = 2
) (
  input  logic                    adc_clk,
  input  logic                    top_rst,
  // calibrated generator samples
  input  sample_t [CHN-1:0]       smp_i,
  // dac pins, both channels in parallel
  output logic [CHN-1:0][14-1:0]  dac_dat_o
);

  // code of a zero sample, the dac midscale
  localparam logic [14-1:0] DAC_ZERO = {1'b0, {13{1'b1}}};

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= {CHN{DAC_ZERO}};
    end else begin
      for (int i = 0; i < CHN; i++) begin
        // sign kept, magnitude bits flipped
        dac_dat_o[i] <= {smp_i[i][14-1], ~smp_i[i][14-2:0]};
      end
    end
  end

endmodule : rp_dac_out

// ==== verilog/rp_top.sv ====
// acquisition and generation signal path
// register bank, adc front end, calibration stages and dac formatter

module rp_top import rp_dsp_pkg::*, rp_bus_pkg::*; #(
  parameter int unsigned CHN = 2
) (
  input  logic                    adc_clk,
  input  logic                    top_rst,
  // adc pins
  input  adc_raw_t [CHN-1:0]      adc_dat_i,
  // generator samples
  input  sample_t [CHN-1:0]       gen_dat_i,
  // register bus
  input  bus_req_t                bus_req_i,
  output bus_rsp_t                bus_rsp_o,
  // calibrated acquisition stream
  output sample_t [CHN-1:0]       osc_dat_o,
  // dac pins
  output logic [CHN-1:0][14-1:0]  dac_dat_o
);

  //////////////////////////////
  // local signals
  //////////////////////////////

  // settings
  logic [CHN-1:0]    loop;
  cal_t [CHN-1:0]    adc_cal;
  cal_t [CHN-1:0]    dac_cal;
  // streams between blocks
  sample_t [CHN-1:0] adc_smp;
  sample_t [CHN-1:0] dac_smp;

  // decode
  rp_regs #(.CHN (CHN)) regs_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .loop_o    (loop),
    .adc_cal_o (adc_cal),
    .dac_cal_o (dac_cal)
  );

  //////////////////////////////
  // acquisition
  //////////////////////////////

  // capture plus loopback select
  rp_adc_front #(.CHN (CHN)) adc_front_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .loop_i    (loop),
    .dac_smp_i (dac_smp),
    .adc_smp_o (adc_smp)
  );

  rp_linear #(.CHN (CHN)) linear_adc (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (adc_smp),
    .cal_i   (adc_cal),
    .smp_o   (osc_dat_o)
  );

  //////////////////////////////
  // generation
  //////////////////////////////

  // output also feeds the loopback path
  rp_linear #(.CHN (CHN)) linear_dac (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (gen_dat_i),
    .cal_i   (dac_cal),
    .smp_o   (dac_smp)
  );

  rp_dac_out #(.CHN (CHN)) dac_out_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .smp_i     (dac_smp),
    .dac_dat_o (dac_dat_o)
  );

endmodule : rp_top

// ==== verif/rp_tb_clk.sv ====
// testbench clock and reset
// free running adc clock, reset held for the first few cycles

module rp_tb_clk #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 3
) (
  output logic adc_clk,
  output logic top_rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    adc_clk = 1'b0;
    forever #(PERIOD_NS / 2) adc_clk = ~adc_clk;
  end

  // released on a rising edge, like any other input
  initial begin
    top_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge adc_clk);
    top_rst <= 1'b0;
  end

endmodule : rp_tb_clk

// ==== verif/rp_tb.sv ====
// testbench for the acquisition and generation path
// random stimulus, reference model in delay lines, concurrent checks

module rp_tb import rp_dsp_pkg::*, rp_bus_pkg::*; #(
  parameter int unsigned CHN = 2
) ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADC0        = int'(ADDR_ADC_CAL);
  localparam int DAC0        = int'(ADDR_DAC_CAL);
  localparam int BUS_TIMEOUT = 16;

  logic                    adc_clk;
  logic                    top_rst;
  adc_raw_t [CHN-1:0]      adc_dat = '0;
  sample_t [CHN-1:0]       gen_dat = '0;
  bus_req_t                bus_req = '0;
  bus_rsp_t                bus_rsp;
  sample_t [CHN-1:0]       osc_dat;
  logic [CHN-1:0][14-1:0]  dac_dat;

  // model of the register contents, reset values
  logic [CHN-1:0] m_loop                  = '0;
  gain_t          m_adc_gain [CHN]        = '{default: 16'sd16384};
  offset_t        m_adc_off  [CHN]        = '{default: 14'sd0};
  gain_t          m_dac_gain [CHN]        = '{default: 16'sd16384};
  offset_t        m_dac_off  [CHN]        = '{default: 14'sd0};

  // expected values, 3 deep for adc and dac, 4 deep for loopback
  sample_t [CHN-1:0]      a_exp [3];
  sample_t [CHN-1:0]      l_exp [4];
  logic [CHN-1:0][14-1:0] g_exp [3];
  logic [CHN-1:0]         a_vld [3] = '{default: '0};
  logic [CHN-1:0]         l_vld [4] = '{default: '0};
  logic [CHN-1:0]         g_vld [3] = '{default: '0};
  logic [CHN-1:0]         osc_bad;
  logic [CHN-1:0]         dac_bad;

  logic        check_en = 1'b0;
  logic        hung     = 1'b0;
  int unsigned rng      = 98837;
  int          osc_err  = 0;
  int          dac_err  = 0;
  int          ack_err  = 0;
  int          rd_err   = 0;
  int          mark     = 0;
  int          n_tests  = 0;

  rp_tb_clk #(.PERIOD_NS (20), .RST_CYCLES (3)) clk_gen_i (
    .adc_clk (adc_clk),
    .top_rst (top_rst)
  );

  rp_top #(.CHN (CHN)) dut_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat),
    .gen_dat_i (gen_dat),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .osc_dat_o (osc_dat),
    .dac_dat_o (dac_dat)
  );

  //////////////////////////////
  // reference model
  //////////////////////////////

  // xorshift32
  function automatic int unsigned next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // gain/16384 with floor, then offset, then clip to 14-bit signed
  function automatic int cal_ref(input int smp, input gain_t gain, input offset_t off);
    int val;
    val = ((smp * int'(gain)) >>> GAIN_SHIFT) + int'(off);
    if (val > 8191) val = 8191;
    if (val < -8192) val = -8192;
    return val;
  endfunction

  // stored word as the register map defines it
  function automatic data_t expect_word(input int a);
    if (a == int'(ADDR_CTL)) return data_t'(m_loop);
    if (a >= ADC0 && a < ADC0 + CHN) return {2'b00, m_adc_gain[a - ADC0], m_adc_off[a - ADC0]};
    if (a >= DAC0 && a < DAC0 + CHN) return {2'b00, m_dac_gain[a - DAC0], m_dac_off[a - DAC0]};
    return '0;
  endfunction

  function automatic int total_errors();
    return osc_err + dac_err + ack_err + rd_err;
  endfunction

  // both conversions reduce to code = 8191 - value
  always @(posedge adc_clk) begin
    int d;
    for (int i = 0; i < CHN; i++) begin
      d = cal_ref(int'(gen_dat[i]), m_dac_gain[i], m_dac_off[i]);
      a_exp[0][i] <= sample_t'(cal_ref(8191 - int'(adc_dat[i]), m_adc_gain[i], m_adc_off[i]));
      a_vld[0][i] <= check_en && !m_loop[i];
      l_exp[0][i] <= sample_t'(cal_ref(d, m_adc_gain[i], m_adc_off[i]));
      l_vld[0][i] <= check_en && m_loop[i];
      g_exp[0][i] <= 14'(8191 - d);
      g_vld[0][i] <= check_en;
    end
    for (int s = 1; s < 4; s++) begin
      l_exp[s] <= l_exp[s-1];
      l_vld[s] <= l_vld[s-1];
    end
    for (int s = 1; s < 3; s++) begin
      a_exp[s] <= a_exp[s-1];
      a_vld[s] <= a_vld[s-1];
      g_exp[s] <= g_exp[s-1];
      g_vld[s] <= g_vld[s-1];
    end
  end

  always_comb begin
    for (int i = 0; i < CHN; i++) begin
      osc_bad[i] = (a_vld[2][i] && osc_dat[i] != a_exp[2][i]) ||
                   (l_vld[3][i] && osc_dat[i] != l_exp[3][i]);
      dac_bad[i] = g_vld[2][i] && dac_dat[i] != g_exp[2][i];
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  a_osc : assert property (@(posedge adc_clk) disable iff (top_rst) osc_bad == '0)
    else begin
      osc_err++;
      $display("ERR %0t: osc_dat_o mismatch, channel mask %b", $time, $sampled(osc_bad));
    end

  a_dac : assert property (@(posedge adc_clk) disable iff (top_rst) dac_bad == '0)
    else begin
      dac_err++;
      $display("ERR %0t: dac_dat_o mismatch, channel mask %b", $time, $sampled(dac_bad));
    end

  // ack trails req by one cycle on both edges
  a_ack : assert property (@(posedge adc_clk) disable iff (top_rst)
    bus_rsp.ack == $past(bus_req.req))
    else begin
      ack_err++;
      $display("ERR %0t: ack does not follow req by one cycle", $time);
    end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic wait_reset();
    int n;
    n = 0;
    do begin
      @(posedge adc_clk);
      n++;
    end while (top_rst && n < BUS_TIMEOUT);
    if (top_rst) begin
      hung = 1'b1;
      $display("timeout: reset was never released");
    end
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    do begin
      @(posedge adc_clk);
      n++;
    end while (bus_rsp.ack != level && n < BUS_TIMEOUT);
    if (bus_rsp.ack != level) begin
      hung = 1'b1;
      $display("timeout: ack did not go to %0d within %0d cycles", level, BUS_TIMEOUT);
    end
  endtask

  // one four-phase access
  task automatic bus_access(input logic we, input int a, input data_t wdata,
                            output data_t rdata);
    bus_req <= '{req: 1'b1, we: we, addr: addr_t'(a), wdata: wdata};
    wait_ack(1'b1);
    rdata = bus_rsp.rdata;
    bus_req.req <= 1'b0;
    wait_ack(1'b0);
  endtask

  // write and keep the model in step
  task automatic write_reg(input int a, input data_t d);
    data_t rd;
    bus_access(1'b1, a, d, rd);
    if (a == int'(ADDR_CTL)) begin
      m_loop <= d[CHN-1:0];
    end else if (a >= ADC0 && a < ADC0 + CHN) begin
      m_adc_gain[a - ADC0] <= gain_t'(d[29:14]);
      m_adc_off[a - ADC0]  <= offset_t'(d[13:0]);
    end else if (a >= DAC0 && a < DAC0 + CHN) begin
      m_dac_gain[a - DAC0] <= gain_t'(d[29:14]);
      m_dac_off[a - DAC0]  <= offset_t'(d[13:0]);
    end
  endtask

  task automatic check_read(input int a);
    data_t rd;
    bus_access(1'b0, a, '0, rd);
    assert (rd == expect_word(a))
      else begin
        rd_err++;
        $display("ERR %0t: read of address %0d gave %h, expected %h",
                 $time, a, rd, expect_word(a));
      end
  endtask

  // nothing checked while settings change
  task automatic drain();
    check_en <= 1'b0;
    repeat (6) @(posedge adc_clk);
  endtask

  task automatic run_stream(input int cycles);
    int unsigned r;
    check_en <= 1'b1;
    repeat (cycles) begin
      for (int i = 0; i < CHN; i++) begin
        r = next_rand();
        // about one in eight at a full scale code
        adc_dat[i] <= (r[2:0] == 3'd0) ? {14{r[3]}} : adc_raw_t'(r >> 4);
        r = next_rand();
        gen_dat[i] <= (r[2:0] == 3'd0) ? {r[3], {13{~r[3]}}} : sample_t'(r >> 4);
      end
      @(posedge adc_clk);
    end
    drain();
  endtask

  task automatic end_test(input string name);
    int now;
    now = total_errors();
    $display("test %s: %0d errors", name, now - mark);
    mark = now;
    n_tests++;
  endtask

  initial begin
    wait_reset();

    // defaults after reset
    assert (bus_rsp.ack == 1'b0)
      else begin
        rd_err++;
        $display("ERR %0t: ack high after reset", $time);
      end
    for (int a = 0; a < 8; a++) check_read(a);
    run_stream(64);
    end_test("reset_defaults");

    // random words, read back, unmapped address
    for (int a = 0; a < 5; a++) write_reg(a, data_t'(next_rand()));
    write_reg(7, data_t'(next_rand()));
    for (int a = 0; a < 8; a++) check_read(a);
    write_reg(int'(ADDR_CTL), '0);
    end_test("register_access");

    // random adc calibration, then near double gain to hit both limits
    for (int i = 0; i < CHN; i++) write_reg(ADC0 + i, data_t'(next_rand()));
    run_stream(200);
    for (int i = 0; i < CHN; i++) write_reg(ADC0 + i, {2'b00, 16'h7fff, 14'(next_rand())});
    run_stream(100);
    end_test("adc_calibration");

    for (int i = 0; i < CHN; i++) write_reg(DAC0 + i, data_t'(next_rand()));
    run_stream(200);
    end_test("dac_path");

    // one channel looped at a time
    write_reg(int'(ADDR_CTL), 32'd1);
    run_stream(100);
    write_reg(int'(ADDR_CTL), 32'd2);
    run_stream(100);
    write_reg(int'(ADDR_CTL), '0);
    end_test("loopback");

    $display("tests %0d, errors %0d, timeout %0d", n_tests, total_errors(), hung);
    if (total_errors() == 0 && !hung) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : rp_tb

// ==== files.f ====
verilog/rp_dsp_pkg.sv
verilog/rp_bus_pkg.sv
verilog/rp_regs.sv
verilog/rp_adc_front.sv
verilog/rp_linear.sv
verilog/rp_dac_out.sv
verilog/rp_top.sv
verif/rp_tb_clk.sv
verif/rp_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it and check for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps --top-module rp_tb -f files.f
out=$(./obj_dir/Vrp_tb)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
